// ==== filelist.f ====
trig_seq_pkg.sv
seq_status_if.sv
trig_input_cond.sv
trig_seq_cfg.sv
trigger_sequencer.sv
trig_out_report.sv
trig_seq_top.sv
tb_trig_seq.sv

// ==== Makefile ====
# Verilator flow for the trigger sequencer
TOP := tb_trig_seq

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module trig_seq_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_trig_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_trig_seq
  import trig_seq_pkg::*;
();

  localparam int   num_trig       = 4;
  localparam int   timeout_cycles = 2000;
  localparam win_t no_edge        = 16'hffff;   // gap of an edge that never comes

  logic                adc_clk = 1'b0;
  logic                arst_n;
  logic [num_trig-1:0] trig_in;
  logic                cfg_we;
  cfg_addr_t           cfg_addr;
  reg_data_t           cfg_wdata;
  reg_data_t           cfg_rdata;
  logic                trig_out;
  logic [num_trig-1:0] active_mask;
  logic [7:0]          drop_count;
  logic                rpt_valid;
  logic                rpt_ready;
  report_t             rpt_data;

  win_t      min_w [num_trig] = '{16'd4, 16'd6, 16'd3, 16'd0};
  win_t      max_w [num_trig] = '{16'd20, 16'd25, 16'd18, 16'd0};
  win_t      gaps  [num_trig];        // cycles between edge k and edge k+1 on trig_in
  reg_data_t reg_exp [8];
  report_t   held [3];
  report_t   exp_q [$];               // records the model expects, oldest first
  report_t   exp_rec;
  report_t   rec;
  int        seed = 32'h822d_60a3;
  int        errors = 0;
  int        err_mark;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        trig_seen;
  int        exp_trig;
  string     test_name;

  always #4 adc_clk = ~adc_clk;

  trig_seq_top #(
    .num_trig (num_trig)
  ) u_dut (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .trig_in     (trig_in),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .trig_out    (trig_out),
    .active_mask (active_mask),
    .drop_count  (drop_count),
    .rpt_valid   (rpt_valid),
    .rpt_ready   (rpt_ready),
    .rpt_data    (rpt_data)
  );

  // window rule: edge k+1 counts if min <= gap and, with a nonzero max, gap <= max
  function automatic report_t model_attempt(input win_t mins [num_trig],
                                            input win_t maxs [num_trig],
                                            input slot_t last, input win_t g [num_trig]);
    report_t r;
    r.res   = res_fired;
    r.slot  = last;
    r.count = win_t'(1);
    for (int k = 0; k < int'(last); k++) begin
      if (g[k] < mins[k] || (maxs[k] != '0 && g[k] > maxs[k])) begin
        r.res   = res_late;   // window k ran out while waiting for channel k+1
        r.slot  = slot_t'(k + 1);
        r.count = maxs[k];
        return r;
      end
      r.count = g[k];
    end
    return r;
  endfunction

  // compare every delivered record against the model, count trigger pulses
  always @(posedge adc_clk) begin
    if (arst_n && trig_out)
      trig_seen++;
    if (arst_n && rpt_valid && rpt_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("%s: report %h arrived with none expected", test_name, rpt_data);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        assert (rpt_data == exp_rec) else begin
          $display("mismatch %s: report expected %h actual %h", test_name, exp_rec, rpt_data);
          errors++;
        end
      end
    end
  end

  task automatic idle(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic write_reg(input cfg_addr_t a, input reg_data_t d);
    @(posedge adc_clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    @(posedge adc_clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic write_ctrl(input logic arm, input logic byp, input slot_t last);
    write_reg(ctrl_addr, {8'h00, 1'b0, last, 2'b00, byp, arm});
  endtask

  task automatic check_reg(input cfg_addr_t a, input reg_data_t exp);
    @(posedge adc_clk);
    cfg_addr <= a;
    @(posedge adc_clk);
    assert (cfg_rdata == exp) else begin
      $display("mismatch %s: addr %0d expected %h actual %h", test_name, a, exp, cfg_rdata);
      errors++;
    end
  endtask

  task automatic program_windows();
    for (int k = 0; k < num_trig; k++) begin
      write_reg(cfg_addr_t'(2 * k), min_w[k]);
      write_reg(cfg_addr_t'(2 * k + 1), max_w[k]);
    end
  endtask

  // channel k rises gaps[k-1] cycles after channel k-1 and stays high
  task automatic drive_edges(input int n_edges);
    for (int k = 0; k < n_edges; k++) begin
      @(posedge adc_clk);
      trig_in[k] <= 1'b1;
      if (k < n_edges - 1)
        repeat (int'(gaps[k]) - 1) @(posedge adc_clk);
    end
  endtask

  task automatic release_inputs();
    @(posedge adc_clk);
    trig_in <= '0;
    idle(6);
  endtask

  task automatic wait_reports_drained();
    int cyc;
    cyc = 0;
    while (exp_q.size() != 0 && cyc < timeout_cycles) begin
      @(posedge adc_clk);
      cyc++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: timed out with %0d report(s) missing", test_name, exp_q.size());
      errors++;
    end
  endtask

  task automatic wait_trigs(input int n);
    int cyc;
    cyc = 0;
    while (trig_seen < n && cyc < timeout_cycles) begin
      @(posedge adc_clk);
      cyc++;
    end
    assert (trig_seen >= n) else begin
      $display("%s: timed out waiting for trig_out", test_name);
      errors++;
    end
  endtask

  // the sequencer leaves slot 0, then comes back once the attempt is over
  task automatic wait_attempt_end();
    int cyc;
    cyc = 0;
    while (active_mask == 4'b0001 && cyc < timeout_cycles) begin
      @(posedge adc_clk);
      cyc++;
    end
    while (active_mask != 4'b0001 && cyc < timeout_cycles) begin
      @(posedge adc_clk);
      cyc++;
    end
    assert (cyc < timeout_cycles) else begin
      $display("%s: attempt never ended", test_name);
      errors++;
    end
  endtask

  task automatic run_attempt(input slot_t last, input int n_edges);
    rec = model_attempt(min_w, max_w, last, gaps);
    exp_q.push_back(rec);
    if (rec.res == res_fired)
      exp_trig++;
    drive_edges(n_edges);
    wait_reports_drained();
    release_inputs();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
    trig_seen = 0;
    exp_trig  = 0;
  endtask

  task automatic end_test();
    assert (trig_seen == exp_trig) else begin
      $display("mismatch %s: trig_out pulses expected %0d actual %0d",
               test_name, exp_trig, trig_seen);
      errors++;
    end
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d error(s)", test_name, errors - err_mark);
    end
  endtask

  initial begin
    reg_data_t wdata;
    reg_data_t ctrl_exp;
    arst_n    = 1'b0;
    trig_in   = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    rpt_ready = 1'b1;
    idle(8);
    arst_n <= 1'b1;
    idle(2);

    start_test("reg_readback");
    for (int a = 0; a < 8; a++) begin
      reg_exp[a] = reg_data_t'($random(seed));
      write_reg(cfg_addr_t'(a), reg_exp[a]);
    end
    for (int a = 0; a < 8; a++)
      check_reg(cfg_addr_t'(a), reg_exp[a]);
    wdata         = 16'h0a72;   // bypass, last 7, channels 1 and 3 inverted
    ctrl_exp      = wdata;
    ctrl_exp[6:4] = 3'd3;       // clamped to the highest channel
    write_reg(ctrl_addr, wdata);
    check_reg(ctrl_addr, ctrl_exp);
    write_reg(ctrl_addr, 16'h0000);
    end_test();

    start_test("in_window");
    program_windows();
    write_ctrl(1'b1, 1'b0, 3'd3);
    for (int a = 0; a < 4; a++) begin
      for (int k = 0; k < num_trig - 1; k++)
        gaps[k] = min_w[k] + win_t'($unsigned($random(seed)) % (max_w[k] - min_w[k] + 1));
      gaps[num_trig-1] = '0;
      run_attempt(3'd3, 4);
    end
    end_test();

    start_test("early_edge");
    gaps = '{16'd10, 16'd20, 16'd5, 16'd0};
    rec  = model_attempt(min_w, max_w, 3'd3, gaps);
    exp_q.push_back(rec);
    if (rec.res == res_fired)
      exp_trig++;
    @(posedge adc_clk);
    trig_in[0] <= 1'b1;
    idle(2);
    trig_in[1] <= 1'b1;   // gap 2, below min_wait[0]
    idle(3);
    trig_in[1] <= 1'b0;
    idle(5);
    trig_in[1] <= 1'b1;   // 10 cycles after channel 0
    idle(20);             // 28 cycles after the early edge, past max_wait[1]
    trig_in[2] <= 1'b1;
    idle(5);
    trig_in[3] <= 1'b1;
    wait_reports_drained();
    release_inputs();
    end_test();

    start_test("late_and_short");
    gaps = '{16'd5, no_edge, 16'd0, 16'd0};
    run_attempt(3'd3, 2);
    max_w[0] = '0;        // open-ended first window
    write_reg(4'd1, max_w[0]);
    write_ctrl(1'b1, 1'b0, 3'd1);
    gaps = '{16'd300, 16'd0, 16'd0, 16'd0};
    run_attempt(3'd1, 2);
    max_w[0] = 16'd20;
    write_reg(4'd1, max_w[0]);
    end_test();

    start_test("bypass_disarm");
    write_ctrl(1'b1, 1'b1, 3'd3);
    idle(2);
    assert (active_mask == 4'hf) else begin
      $display("mismatch %s: active_mask expected f actual %h", test_name, active_mask);
      errors++;
    end
    for (int a = 0; a < 3; a++) begin
      trig_in[0] <= 1'b1;
      idle(3);
      trig_in[0] <= 1'b0;
      idle(3);
    end
    exp_trig = 3;
    wait_trigs(exp_trig);
    idle(10);
    write_ctrl(1'b1, 1'b0, 3'd3);
    idle(3);
    gaps = '{16'd5, 16'd8, 16'd5, 16'd0};
    drive_edges(2);
    write_ctrl(1'b0, 1'b0, 3'd3);   // drop arm halfway through
    trig_in <= 4'hf;
    idle(60);
    release_inputs();
    end_test();

    start_test("back_pressure");
    write_ctrl(1'b1, 1'b0, 3'd3);
    rpt_ready <= 1'b0;
    for (int a = 0; a < 3; a++) begin
      gaps    = '{16'd5, 16'd8, 16'd5, 16'd0};
      gaps[a] = no_edge;            // attempt a stalls before channel a+1
      held[a] = model_attempt(min_w, max_w, 3'd3, gaps);
      drive_edges(a + 1);
      wait_attempt_end();
      release_inputs();
    end
    // two entries held, so the third record is the one lost
    assert (drop_count == 8'd1) else begin
      $display("mismatch %s: drop_count expected 1 actual %0d", test_name, drop_count);
      errors++;
    end
    exp_q.push_back(held[0]);
    exp_q.push_back(held[1]);
    @(posedge adc_clk);
    rpt_ready <= 1'b1;
    wait_reports_drained();
    idle(4);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== trig_seq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_seq_top
  import trig_seq_pkg::*;
#(
  parameter int num_trig = 4
) (
  input  wire                 adc_clk,
  input  wire                 arst_n,
  input  wire [num_trig-1:0]  trig_in,
  input  wire                 cfg_we,
  input  wire cfg_addr_t      cfg_addr,
  input  wire reg_data_t      cfg_wdata,
  output reg_data_t           cfg_rdata,
  output logic                trig_out,
  output logic [num_trig-1:0] active_mask,
  output logic [7:0]          drop_count,
  output logic                rpt_valid,
  input  wire                 rpt_ready,
  output report_t             rpt_data
);

  logic [num_trig-1:0] trig_edge;
  logic [num_trig-1:0] pol_inv;
  win_t                min_wait [num_trig];
  win_t                max_wait [num_trig];
  slot_t               last_trigger;
  logic                bypass;
  logic                armed;

  seq_status_if u_status ();

  trig_input_cond #(
    .num_trig (num_trig)
  ) u_input (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .trig_in   (trig_in),
    .pol_inv   (pol_inv),
    .trig_edge (trig_edge)
  );

  trig_seq_cfg #(
    .num_trig (num_trig)
  ) u_cfg (
    .adc_clk      (adc_clk),
    .arst_n       (arst_n),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .min_wait     (min_wait),
    .max_wait     (max_wait),
    .last_trigger (last_trigger),
    .bypass       (bypass),
    .armed        (armed),
    .pol_inv      (pol_inv)
  );

  trigger_sequencer #(
    .num_trig (num_trig)
  ) u_seq (
    .adc_clk      (adc_clk),
    .arst_n       (arst_n),
    .trig_edge    (trig_edge),
    .min_wait     (min_wait),
    .max_wait     (max_wait),
    .last_trigger (last_trigger),
    .bypass       (bypass),
    .armed        (armed),
    .active_mask  (active_mask),
    .st           (u_status.seq)
  );

  trig_out_report u_out (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .st         (u_status.report),
    .trig_out   (trig_out),
    .rpt_valid  (rpt_valid),
    .rpt_ready  (rpt_ready),
    .rpt_data   (rpt_data),
    .drop_count (drop_count)
  );

endmodule

`default_nettype wire

// ==== trig_out_report.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_out_report
  import trig_seq_pkg::*;
(
  input  wire           adc_clk,
  input  wire           arst_n,
  seq_status_if.report  st,
  output logic          trig_out,
  output logic          rpt_valid,
  input  wire           rpt_ready,
  output report_t       rpt_data,
  output logic [7:0]    drop_count
);

  report_t    q_mem [2];   // two-entry report queue
  report_t    rec;
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] q_cnt;
  logic       from_bypass;
  logic       push;
  logic       pop;
  logic       accept;

  // a real sequence never reports count 0, the counter restarts at 1
  assign from_bypass = st.fire && st.slot == '0 && st.count == '0;
  assign push        = (st.fire && !from_bypass) || st.fail_late;

  assign rec.res   = st.fire ? res_fired : res_late;
  assign rec.slot  = st.slot;
  assign rec.count = st.count;

  assign rpt_valid = (q_cnt != 2'd0);
  assign rpt_data  = q_mem[rd_ptr];
  assign pop       = rpt_valid && rpt_ready;
  assign accept    = push && (q_cnt != 2'd2 || pop);   // full queue frees a slot on pop

  // trigger path bypasses the queue, back-pressure never delays it
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n)
      trig_out <= 1'b0;
    else
      trig_out <= st.fire;
  end

  always_ff @(posedge adc_clk) begin
    if (accept)
      q_mem[wr_ptr] <= rec;
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      q_cnt      <= 2'd0;
      drop_count <= 8'd0;
    end else begin
      if (accept)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      case ({accept, pop})
        2'b10:   q_cnt <= q_cnt + 2'd1;
        2'b01:   q_cnt <= q_cnt - 2'd1;
        default: q_cnt <= q_cnt;
      endcase
      if (push && !accept && drop_count != 8'hff)
        drop_count <= drop_count + 8'd1;   // saturating
    end
  end

  a_rpt_hold : assert property (@(posedge adc_clk) disable iff (!arst_n)
    rpt_valid && !rpt_ready |=> rpt_valid && $stable(rpt_data))
    else $error("report changed while stalled");

endmodule

`default_nettype wire

// ==== trigger_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_sequencer
  import trig_seq_pkg::*;
#(
  parameter int num_trig = 4
) (
  input  wire                 adc_clk,
  input  wire                 arst_n,
  input  wire [num_trig-1:0]  trig_edge,
  input  wire win_t           min_wait [num_trig],
  input  wire win_t           max_wait [num_trig],
  input  wire slot_t          last_trigger,
  input  wire                 bypass,
  input  wire                 armed,
  output logic [num_trig-1:0] active_mask,
  seq_status_if.seq           st
);

  seq_state_t state;
  seq_state_t state_nxt;
  slot_t      slot;       // channel being waited for
  slot_t      slot_nxt;
  win_t       counter;    // cycles since the last accepted edge
  win_t       cur_min;    // window in front of the awaited slot
  win_t       cur_max;
  logic       enabled;
  logic       edge_hit;   // edge on the awaited channel
  logic       restart;
  logic       fire_nxt;
  logic       late_nxt;

  function automatic logic [num_trig-1:0] slot_onehot(slot_t s);
    logic [num_trig-1:0] m;
    m = '0;
    for (int k = 0; k < num_trig; k++) begin
      if (s == slot_t'(k))
        m[k] = 1'b1;
    end
    return m;
  endfunction

  assign enabled  = armed && !bypass;
  assign edge_hit = |(trig_edge & slot_onehot(slot));

  // window k guards the gap between channel k and channel k+1
  always_comb begin
    cur_min = '0;
    cur_max = '0;
    for (int k = 0; k < num_trig - 1; k++) begin
      if (slot == slot_t'(k + 1)) begin
        cur_min = min_wait[k];
        cur_max = max_wait[k];
      end
    end
  end

  always_comb begin
    state_nxt = state;
    slot_nxt  = slot;
    restart   = 1'b0;
    fire_nxt  = 1'b0;
    late_nxt  = 1'b0;
    unique case (state)
      seq_idle: begin
        slot_nxt = '0;
        if (enabled)
          state_nxt = seq_wait_first;
      end
      seq_wait_first: begin
        if (!enabled) begin
          state_nxt = seq_idle;
        end else if (trig_edge[0]) begin
          restart = 1'b1;
          if (last_trigger == '0) begin     // single-channel sequence
            fire_nxt  = 1'b1;
            state_nxt = seq_idle;
          end else begin
            slot_nxt  = slot_t'(1);
            state_nxt = seq_wait_next;
          end
        end
      end
      seq_wait_next: begin
        if (!enabled) begin
          state_nxt = seq_idle;            // disarm drops the attempt silently
        end else if (edge_hit && counter >= cur_min) begin
          if (slot == last_trigger) begin
            fire_nxt  = 1'b1;
            state_nxt = seq_idle;
          end else begin
            slot_nxt = slot + 1'b1;
            restart  = 1'b1;
          end
        end else if (cur_max != '0 && counter == cur_max) begin
          late_nxt  = 1'b1;                // early edges fall through to here
          state_nxt = seq_idle;
        end
      end
      default: state_nxt = seq_idle;
    endcase
    if (bypass)
      fire_nxt = trig_edge[0];             // channel 0 passes straight through
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= seq_idle;
      slot        <= '0;
      counter     <= '0;
      active_mask <= '0;
      st.fire     <= 1'b0;
      st.fail_late <= 1'b0;
    end else begin
      state        <= state_nxt;
      slot         <= slot_nxt;
      active_mask  <= bypass ? '1 : slot_onehot(slot_nxt);
      st.fire      <= fire_nxt;
      st.fail_late <= late_nxt;
      if (restart)
        counter <= win_t'(1);
      else if (state == seq_wait_next && counter != '1)
        counter <= counter + 1'b1;         // saturates at all ones
    end
  end

  // report payload, slot 0 with count 0 marks a bypass pulse
  always_ff @(posedge adc_clk) begin
    if (bypass) begin
      st.slot  <= '0;
      st.count <= '0;
    end else begin
      st.slot  <= slot;
      st.count <= (state == seq_wait_first) ? win_t'(1) : counter;
    end
  end

  a_fire_xor_late : assert property (@(posedge adc_clk) disable iff (!arst_n)
    !(st.fire && st.fail_late))
    else $error("fire and fail_late in the same cycle");

  // mask catches up one cycle after reset or bypass
  a_mask_onehot : assert property (@(posedge adc_clk) disable iff (!arst_n)
    $past(arst_n) && !$past(bypass) && !bypass |-> $onehot(active_mask))
    else $error("active_mask not one-hot: %b", active_mask);

endmodule

`default_nettype wire

// ==== trig_seq_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_seq_cfg
  import trig_seq_pkg::*;
#(
  parameter int num_trig = 4
) (
  input  wire                 adc_clk,
  input  wire                 arst_n,
  input  wire                 cfg_we,
  input  wire cfg_addr_t      cfg_addr,
  input  wire reg_data_t      cfg_wdata,
  output reg_data_t           cfg_rdata,
  output win_t                min_wait [num_trig],
  output win_t                max_wait [num_trig],
  output slot_t               last_trigger,
  output logic                bypass,
  output logic                armed,
  output logic [num_trig-1:0] pol_inv
);

  logic  ctrl_sel;   // control word addressed
  slot_t win_idx;    // window index, address bits 3:1
  slot_t wr_last;    // last_trigger after clamping

  assign ctrl_sel = (cfg_addr == ctrl_addr);
  assign win_idx  = cfg_addr[3:1];

  // never let the sequencer wait on a channel that does not exist
  assign wr_last = (cfg_wdata[6:4] > slot_t'(num_trig - 1)) ? slot_t'(num_trig - 1)
                                                            : cfg_wdata[6:4];

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < num_trig; k++) begin
        min_wait[k] <= '0;
        max_wait[k] <= '0;
      end
      last_trigger <= '0;
      bypass       <= 1'b0;
      armed        <= 1'b0;
      pol_inv      <= '0;
    end else if (cfg_we) begin
      if (ctrl_sel) begin
        armed        <= cfg_wdata[0];
        bypass       <= cfg_wdata[1];
        last_trigger <= wr_last;
        pol_inv      <= cfg_wdata[8 +: num_trig];
      end else begin
        for (int k = 0; k < num_trig; k++) begin
          if (win_idx == slot_t'(k)) begin
            if (cfg_addr[0])
              max_wait[k] <= cfg_wdata;   // odd address
            else
              min_wait[k] <= cfg_wdata;
          end
        end
      end
    end
  end

  // read-back straight from the register storage, unmapped addresses give 0
  always_comb begin
    cfg_rdata = '0;
    if (ctrl_sel) begin
      cfg_rdata[0]              = armed;
      cfg_rdata[1]              = bypass;
      cfg_rdata[6:4]            = last_trigger;
      cfg_rdata[8 +: num_trig]  = pol_inv;
    end else begin
      for (int k = 0; k < num_trig; k++) begin
        if (win_idx == slot_t'(k))
          cfg_rdata = cfg_addr[0] ? max_wait[k] : min_wait[k];
      end
    end
  end

  a_last_in_range : assert property (@(posedge adc_clk) disable iff (!arst_n)
    last_trigger <= slot_t'(num_trig - 1))
    else $error("last_trigger %0d beyond channel count", last_trigger);

endmodule

`default_nettype wire

// ==== trig_input_cond.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_input_cond #(
  parameter int num_trig = 4
) (
  input  wire                adc_clk,
  input  wire                arst_n,
  input  wire [num_trig-1:0] trig_in,
  input  wire [num_trig-1:0] pol_inv,
  output logic [num_trig-1:0] trig_edge
);

  logic [num_trig-1:0] sync_q1;   // first synchronizer stage, may go metastable
  logic [num_trig-1:0] sync_q2;
  logic [num_trig-1:0] level;     // synchronized level after polarity select
  logic [num_trig-1:0] level_q;   // level one cycle ago

  // inverted channels trigger on a falling input
  assign level = sync_q2 ^ pol_inv;

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= trig_in;
      sync_q2 <= sync_q1;
    end
  end

  // edge register, so a pulse appears three cycles after the pin changes
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      level_q   <= '0;
      trig_edge <= '0;
    end else begin
      level_q   <= level;
      trig_edge <= level & ~level_q;   // active-going transitions only
    end
  end

endmodule

`default_nettype wire

// ==== seq_status_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface seq_status_if
  import trig_seq_pkg::*;
();

  logic  fire;       // one-cycle pulse, sequence completed (or bypass edge)
  logic  fail_late;  // one-cycle pulse, window ran out
  slot_t slot;       // valid with either pulse
  win_t  count;

  modport seq (output fire, output fail_late, output slot, output count);

  modport report (input fire, input fail_late, input slot, input count);

endinterface

`default_nettype wire

// ==== trig_seq_pkg.sv ====
`default_nettype none

package trig_seq_pkg;

  // largest channel count the slot index can address
  localparam int num_trig_max = 8;

  typedef logic [15:0] win_t;                        // window or counter value in adc_clk cycles
  typedef logic [$clog2(num_trig_max)-1:0] slot_t;   // channel index

  // outcome of one sequence attempt
  typedef logic [1:0] result_t;
  localparam result_t res_fired = 2'b01;
  localparam result_t res_late  = 2'b10;

  typedef enum logic [1:0] {
    seq_idle,
    seq_wait_first,
    seq_wait_next
  } seq_state_t;

  typedef logic [3:0]  cfg_addr_t;
  typedef logic [15:0] reg_data_t;

  // windows live at 0..7, control word at 8
  localparam cfg_addr_t ctrl_addr = 4'd8;

  typedef struct packed {
    result_t res;    // fired or late
    slot_t   slot;   // slot reached when the attempt ended
    win_t    count;  // window counter at the end
  } report_t;

endpackage

`default_nettype wire
